//--- design/cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_W    = 16;
    localparam int NUM_REGS  = 8;
    localparam int REG_IDX_W = $clog2(NUM_REGS);

    localparam logic [6:0] op_mov = 7'd1;
    localparam logic [6:0] op_ldd = 7'd2;
    localparam logic [6:0] op_ldo = 7'd3;
    localparam logic [6:0] op_ldi = 7'd4;
    localparam logic [6:0] op_std = 7'd5;
    localparam logic [6:0] op_sto = 7'd6;
    localparam logic [6:0] op_add = 7'd7;
    localparam logic [6:0] op_adi = 7'd8;
    localparam logic [6:0] op_adc = 7'd9;
    localparam logic [6:0] op_sub = 7'd10;
    localparam logic [6:0] op_suc = 7'd11;
    localparam logic [6:0] op_cmp = 7'd12;
    localparam logic [6:0] op_cmi = 7'd13;
    localparam logic [6:0] op_jmp = 7'd14;

    localparam logic [3:0] alu_add    = 4'b0000;
    localparam logic [3:0] alu_sub    = 4'b0001;
    localparam logic [3:0] alu_pass_l = 4'b1001;
    localparam logic [3:0] alu_pass_r = 4'b1010;

    typedef struct packed {
        logic [REG_IDX_W-1:0] so_reg;
        logic [REG_IDX_W-1:0] fo_reg;
        logic [REG_IDX_W-1:0] tg_reg;
        logic [6:0]           opcode;
    } instr_reg_t;

    typedef struct packed {
        logic [4:0] unused;
        logic [3:0] cond;
        logic [6:0] opcode;
    } instr_jmp_t;

    typedef union packed {
        instr_reg_t rtype;
        instr_jmp_t jtype;
    } instr_u;

    typedef struct packed {
        logic [DATA_W-1:0] imm;     // right operand when selected
        instr_u            instr;
    } prog_word_t;

    typedef struct packed {
        logic [3:0] spare;
        logic       ovf;
        logic       lt;
        logic       carry;
        logic       eq;
    } flags_t;

    typedef struct packed {
        logic                 pc_inc;
        logic                 pc_ie;
        logic                 reg_in_mux_ctl;
        logic                 alu_r_mux_ctl;
        logic                 alu_cin;
        logic                 ram_write;
        logic                 ram_read;
        logic                 flag_we;
        logic [3:0]           alu_mode;
        logic [REG_IDX_W-1:0] reg_l_ctl;
        logic [REG_IDX_W-1:0] reg_r_ctl;
        logic [NUM_REGS-1:0]  gp_reg_ie;
    } ctrl_t;

    typedef struct packed {
        logic              write;
        logic              read;
        logic [DATA_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

endpackage

//--- design/instr_decoder.sv
module instr_decoder (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            run,
    input  cpu_pkg::instr_u instr,
    input  cpu_pkg::flags_t flags,
    output cpu_pkg::ctrl_t  ctrl
);

    logic jmp_en;

    always_comb begin
        ctrl        = '0;
        ctrl.pc_inc = 1'b1;
        case (instr.rtype.opcode)
            cpu_pkg::op_mov: begin
                ctrl.alu_mode                        = cpu_pkg::alu_pass_l;
                ctrl.reg_l_ctl                       = instr.rtype.fo_reg;
                ctrl.gp_reg_ie[instr.rtype.tg_reg]   = 1'b1;
            end
            cpu_pkg::op_ldd: begin                          // direct address from imm
                ctrl.alu_mode                        = cpu_pkg::alu_pass_r;
                ctrl.alu_r_mux_ctl                   = 1'b1;
                ctrl.reg_in_mux_ctl                  = 1'b1;
                ctrl.ram_read                        = 1'b1;
                ctrl.gp_reg_ie[instr.rtype.tg_reg]   = 1'b1;
            end
            cpu_pkg::op_ldo: begin                          // base reg plus imm
                ctrl.alu_mode                        = cpu_pkg::alu_add;
                ctrl.reg_l_ctl                       = instr.rtype.fo_reg;
                ctrl.alu_r_mux_ctl                   = 1'b1;
                ctrl.reg_in_mux_ctl                  = 1'b1;
                ctrl.ram_read                        = 1'b1;
                ctrl.gp_reg_ie[instr.rtype.tg_reg]   = 1'b1;
            end
            cpu_pkg::op_ldi: begin
                ctrl.alu_mode                        = cpu_pkg::alu_pass_r;
                ctrl.alu_r_mux_ctl                   = 1'b1;
                ctrl.gp_reg_ie[instr.rtype.tg_reg]   = 1'b1;
            end
            cpu_pkg::op_std: begin
                ctrl.alu_mode                        = cpu_pkg::alu_pass_r;
                ctrl.alu_r_mux_ctl                   = 1'b1;
                ctrl.reg_r_ctl                       = instr.rtype.fo_reg;
                ctrl.ram_write                       = 1'b1;
            end
            cpu_pkg::op_sto: begin
                ctrl.alu_mode                        = cpu_pkg::alu_add;
                ctrl.alu_r_mux_ctl                   = 1'b1;
                ctrl.reg_r_ctl                       = instr.rtype.fo_reg;   // store data
                ctrl.reg_l_ctl                       = instr.rtype.so_reg;   // base
                ctrl.ram_write                       = 1'b1;
            end
            cpu_pkg::op_add, cpu_pkg::op_adc: begin
                ctrl.alu_mode                        = cpu_pkg::alu_add;
                ctrl.reg_l_ctl                       = instr.rtype.fo_reg;
                ctrl.reg_r_ctl                       = instr.rtype.so_reg;
                ctrl.alu_cin                         = (instr.rtype.opcode == cpu_pkg::op_adc)
                                                       & flags.carry;
                ctrl.flag_we                         = 1'b1;
                ctrl.gp_reg_ie[instr.rtype.tg_reg]   = 1'b1;
            end
            cpu_pkg::op_adi: begin
                ctrl.alu_mode                        = cpu_pkg::alu_add;
                ctrl.reg_l_ctl                       = instr.rtype.fo_reg;
                ctrl.alu_r_mux_ctl                   = 1'b1;
                ctrl.flag_we                         = 1'b1;
                ctrl.gp_reg_ie[instr.rtype.tg_reg]   = 1'b1;
            end
            cpu_pkg::op_sub, cpu_pkg::op_suc: begin
                ctrl.alu_mode                        = cpu_pkg::alu_sub;
                ctrl.reg_l_ctl                       = instr.rtype.fo_reg;
                ctrl.reg_r_ctl                       = instr.rtype.so_reg;
                ctrl.alu_cin                         = (instr.rtype.opcode == cpu_pkg::op_suc)
                                                       & flags.carry;
                ctrl.flag_we                         = 1'b1;
                ctrl.gp_reg_ie[instr.rtype.tg_reg]   = 1'b1;
            end
            cpu_pkg::op_cmp: begin                          // flags only
                ctrl.alu_mode                        = cpu_pkg::alu_sub;
                ctrl.reg_l_ctl                       = instr.rtype.fo_reg;
                ctrl.reg_r_ctl                       = instr.rtype.so_reg;
                ctrl.flag_we                         = 1'b1;
            end
            cpu_pkg::op_cmi: begin
                ctrl.alu_mode                        = cpu_pkg::alu_sub;
                ctrl.reg_l_ctl                       = instr.rtype.fo_reg;
                ctrl.alu_r_mux_ctl                   = 1'b1;
                ctrl.flag_we                         = 1'b1;
            end
            cpu_pkg::op_jmp: begin                          // target is imm
                ctrl.alu_mode                        = cpu_pkg::alu_pass_r;
                ctrl.alu_r_mux_ctl                   = 1'b1;
                ctrl.pc_ie                           = jmp_en;
                ctrl.pc_inc                          = ~jmp_en;
            end
            default: ctrl.pc_inc = 1'b1;                    // nop
        endcase

        // halted core must not retire anything, including during reset
        if (!run) begin
            ctrl.pc_inc    = 1'b0;
            ctrl.pc_ie     = 1'b0;
            ctrl.ram_write = 1'b0;
            ctrl.ram_read  = 1'b0;
            ctrl.flag_we   = 1'b0;
            ctrl.gp_reg_ie = '0;
        end
    end

    always_comb begin
        case (instr.jtype.cond)
            4'd1:    jmp_en = flags.carry;
            4'd2:    jmp_en = flags.eq;
            4'd3:    jmp_en = flags.lt;
            4'd4:    jmp_en = ~(flags.lt | flags.eq);   // signed greater
            4'd5:    jmp_en = flags.lt | flags.eq;
            4'd6:    jmp_en = ~flags.lt;
            4'd7:    jmp_en = ~flags.eq;
            4'd8,
            4'd9:    jmp_en = flags.ovf;
            default: jmp_en = 1'b1;                     // unconditional
        endcase
    end

    a_one_reg_write: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(ctrl.gp_reg_ie));
    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.ram_write && ctrl.ram_read));
    a_pc_src: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.pc_inc && ctrl.pc_ie));

endmodule

//--- design/fetch_unit.sv
module fetch_unit #(
    parameter  int PROG_DEPTH = 64,
    localparam int PC_W       = $clog2(PROG_DEPTH)
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      run,
    input  logic                      prog_we,
    input  logic [PC_W-1:0]           prog_addr,
    input  cpu_pkg::prog_word_t       prog_wdata,
    input  logic                      pc_inc,
    input  logic                      pc_ie,
    input  logic [cpu_pkg::DATA_W-1:0] jump_target,
    output logic [PC_W-1:0]           pc,
    output cpu_pkg::prog_word_t       word
);

    cpu_pkg::prog_word_t prog_mem [PROG_DEPTH];

    always_ff @(posedge clk) begin
        if (prog_we && !run) begin       // load port only while halted
            prog_mem[prog_addr] <= prog_wdata;
        end
    end

    assign word = prog_mem[pc];          // async read

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_ie) begin
            pc <= jump_target[PC_W-1:0];
        end else if (pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

    a_load_halted: assert property (@(posedge clk) disable iff (!rst_n)
        !(prog_we && run));

endmodule

//--- design/reg_file.sv
module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cpu_pkg::REG_IDX_W-1:0] l_sel,
    input  logic [cpu_pkg::REG_IDX_W-1:0] r_sel,
    input  logic [cpu_pkg::NUM_REGS-1:0]  we,
    input  logic [cpu_pkg::DATA_W-1:0]    wdata,
    output logic [cpu_pkg::DATA_W-1:0]    l_data,
    output logic [cpu_pkg::DATA_W-1:0]    r_data
);

    logic [cpu_pkg::DATA_W-1:0] regs [cpu_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                if (we[i]) begin         // one-hot from decoder
                    regs[i] <= wdata;
                end
            end
        end
    end

    assign l_data = regs[l_sel];
    assign r_data = regs[r_sel];

endmodule

//--- design/alu.sv
module alu (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [3:0]                 mode,
    input  logic [cpu_pkg::DATA_W-1:0] l,
    input  logic [cpu_pkg::DATA_W-1:0] r,
    input  logic                       cin,
    input  logic                       flag_we,
    output logic [cpu_pkg::DATA_W-1:0] result,
    output cpu_pkg::flags_t            flags
);

    localparam int MSB = cpu_pkg::DATA_W - 1;

    logic [cpu_pkg::DATA_W:0] wide;
    logic                     carry;
    logic                     ovf;
    cpu_pkg::flags_t          flags_next;

    always_comb begin
        wide   = '0;
        carry  = 1'b0;
        ovf    = 1'b0;
        result = '0;                     // unknown modes
        case (mode)
            cpu_pkg::alu_add: begin
                wide   = {1'b0, l} + {1'b0, r} + {{cpu_pkg::DATA_W{1'b0}}, cin};
                result = wide[MSB:0];
                carry  = wide[cpu_pkg::DATA_W];
                ovf    = (l[MSB] == r[MSB]) && (result[MSB] != l[MSB]);
            end
            cpu_pkg::alu_sub: begin
                wide   = {1'b0, l} - {1'b0, r} - {{cpu_pkg::DATA_W{1'b0}}, cin};
                result = wide[MSB:0];
                carry  = wide[cpu_pkg::DATA_W];   // borrow
                ovf    = (l[MSB] != r[MSB]) && (result[MSB] != l[MSB]);
            end
            cpu_pkg::alu_pass_l: result = l;
            cpu_pkg::alu_pass_r: result = r;
            default:             result = '0;
        endcase

        flags_next       = '0;
        flags_next.ovf   = ovf;
        flags_next.lt    = result[MSB] ^ ovf;     // signed less-than
        flags_next.carry = carry;
        flags_next.eq    = (result == '0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (flag_we) begin
            flags <= flags_next;
        end
    end

endmodule

//--- design/cpu_core.sv
module cpu_core #(
    parameter  int PROG_DEPTH = 64,
    localparam int PC_W       = $clog2(PROG_DEPTH)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,
    input  logic                       prog_we,
    input  logic [PC_W-1:0]            prog_addr,
    input  cpu_pkg::prog_word_t        prog_wdata,
    output cpu_pkg::mem_req_t          mem_req,
    input  logic [cpu_pkg::DATA_W-1:0] mem_rdata,
    output logic [PC_W-1:0]            pc
);

    cpu_pkg::prog_word_t        word;
    cpu_pkg::ctrl_t             ctrl;
    cpu_pkg::flags_t            flags;
    logic [cpu_pkg::DATA_W-1:0] l_data;
    logic [cpu_pkg::DATA_W-1:0] r_data;
    logic [cpu_pkg::DATA_W-1:0] alu_r;
    logic [cpu_pkg::DATA_W-1:0] alu_result;
    logic [cpu_pkg::DATA_W-1:0] reg_wdata;

    assign alu_r     = ctrl.alu_r_mux_ctl ? word.imm : r_data;
    assign reg_wdata = ctrl.reg_in_mux_ctl ? mem_rdata : alu_result;

    assign mem_req = '{write: ctrl.ram_write, read: ctrl.ram_read,
                       addr: alu_result, wdata: r_data};

    instr_decoder u_decoder (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .instr (word.instr),
        .flags (flags),
        .ctrl  (ctrl)
    );

    fetch_unit #(.PROG_DEPTH(PROG_DEPTH)) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_wdata  (prog_wdata),
        .pc_inc      (ctrl.pc_inc),
        .pc_ie       (ctrl.pc_ie),
        .jump_target (alu_result),   // imm passed through
        .pc          (pc),
        .word        (word)
    );

    reg_file u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .l_sel  (ctrl.reg_l_ctl),
        .r_sel  (ctrl.reg_r_ctl),
        .we     (ctrl.gp_reg_ie),
        .wdata  (reg_wdata),
        .l_data (l_data),
        .r_data (r_data)
    );

    alu u_alu (
        .clk     (clk),
        .rst_n   (rst_n),
        .mode    (ctrl.alu_mode),
        .l       (l_data),
        .r       (alu_r),
        .cin     (ctrl.alu_cin),
        .flag_we (ctrl.flag_we),
        .result  (alu_result),
        .flags   (flags)
    );

endmodule

//--- testbench/tb_cpu_core.sv
module tb_cpu_core;

    timeunit 1ns;
    timeprecision 100ps;

    logic                clk;
    logic                rst_n;
    logic                run;
    logic                prog_we;
    logic [5:0]          prog_addr;
    cpu_pkg::prog_word_t prog_wdata;
    cpu_pkg::mem_req_t   mem_req;
    logic [15:0]         mem_rdata;
    logic [5:0]          pc;

    logic [15:0]         lfsr_state;
    cpu_pkg::prog_word_t prog [64];
    logic [15:0]         ext_mem [256];   // memory seen by the DUT
    logic [15:0]         m_mem [256];     // model copy
    logic [15:0]         m_regs [8];
    logic [5:0]          m_pc;
    logic                m_ovf;
    logic                m_lt;
    logic                m_carry;
    logic                m_eq;

    cpu_core #(.PROG_DEPTH(64)) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_wdata (prog_wdata),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .pc         (pc)
    );

    assign mem_rdata = ext_mem[mem_req.addr[7:0]];   // combinational read

    always @(posedge clk) begin : ext_write
        logic [7:0]  wa;
        logic [15:0] wd;
        if (mem_req.write) begin
            wa = mem_req.addr[7:0];
            wd = mem_req.wdata;
            #1 ext_mem[wa] = wd;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[14:0], lfsr_state[0]};
        end
    endtask

    task automatic check(input string name, input logic [15:0] actual,
                         input logic [15:0] expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic build_program();
        logic [15:0]         opc;
        logic [15:0]         kind;
        logic [15:0]         fields;
        logic [15:0]         imm;
        logic [15:0]         off;
        cpu_pkg::prog_word_t w;
        for (int a = 0; a < 64; a++) begin
            rand_bits(4, opc);
            rand_bits(2, kind);
            if (kind == 16'd0) begin          // extra share of loads and stores
                rand_bits(2, kind);
                case (kind[1:0])
                    2'd0:    opc = {9'd0, cpu_pkg::op_ldd};
                    2'd1:    opc = {9'd0, cpu_pkg::op_ldo};
                    2'd2:    opc = {9'd0, cpu_pkg::op_std};
                    default: opc = {9'd0, cpu_pkg::op_sto};
                endcase
            end
            rand_bits(9, fields);
            rand_bits(16, imm);
            if (opc[6:0] == cpu_pkg::op_jmp) begin
                rand_bits(4, off);
                imm = 16'((a + 1 + int'(off)) % 64);   // forward, wraps at the end
            end
            w.imm                 = imm;
            w.instr.rtype.so_reg  = fields[8:6];
            w.instr.rtype.fo_reg  = fields[5:3];
            w.instr.rtype.tg_reg  = fields[2:0];
            w.instr.rtype.opcode  = opc[6:0];
            prog[a] = w;
        end
    endtask

    task automatic do_arith(input logic [15:0] l, input logic [15:0] r, input logic cin,
                            input logic sub, input logic wb, input logic [2:0] tg);
        int          us;
        int          ss;
        logic [15:0] y;
        if (sub) begin
            us = int'(l) - int'(r) - int'(cin);
            ss = int'($signed(l)) - int'($signed(r)) - int'(cin);
            m_carry = (us < 0);                   // borrow
        end else begin
            us = int'(l) + int'(r) + int'(cin);
            ss = int'($signed(l)) + int'($signed(r)) + int'(cin);
            m_carry = (us > 65535);
        end
        y     = us[15:0];
        m_ovf = (ss > 32767) || (ss < -32768);
        m_lt  = (ss < 0);
        m_eq  = (y == 16'd0);
        if (wb) begin
            m_regs[tg] = y;
        end
    endtask

    function automatic logic jump_taken(input logic [3:0] cond);
        case (cond)
            4'd1:       return m_carry;
            4'd2:       return m_eq;
            4'd3:       return m_lt;
            4'd4:       return !m_lt && !m_eq;
            4'd5:       return m_lt || m_eq;
            4'd6:       return !m_lt;
            4'd7:       return !m_eq;
            4'd8, 4'd9: return m_ovf;
            default:    return 1'b1;
        endcase
    endfunction

    task automatic model_step(output logic wr, output logic rd,
                              output logic [15:0] addr, output logic [15:0] wdata);
        cpu_pkg::prog_word_t w;
        logic [2:0]          tg;
        logic [15:0]         a;
        logic [15:0]         b;
        logic [15:0]         imm;
        logic [5:0]          next_pc;
        w       = prog[m_pc];
        tg      = w.instr.rtype.tg_reg;
        a       = m_regs[w.instr.rtype.fo_reg];
        b       = m_regs[w.instr.rtype.so_reg];
        imm     = w.imm;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wdata   = '0;
        next_pc = m_pc + 6'd1;
        case (w.instr.rtype.opcode)
            cpu_pkg::op_mov: m_regs[tg] = a;
            cpu_pkg::op_ldd, cpu_pkg::op_ldo: begin
                rd         = 1'b1;
                addr       = (w.instr.rtype.opcode == cpu_pkg::op_ldd) ? imm : a + imm;
                m_regs[tg] = m_mem[addr[7:0]];
            end
            cpu_pkg::op_ldi: m_regs[tg] = imm;
            cpu_pkg::op_std, cpu_pkg::op_sto: begin
                wr    = 1'b1;
                addr  = (w.instr.rtype.opcode == cpu_pkg::op_std) ? imm : b + imm;
                wdata = a;
                m_mem[addr[7:0]] = a;
            end
            cpu_pkg::op_add: do_arith(a, b, 1'b0, 1'b0, 1'b1, tg);
            cpu_pkg::op_adi: do_arith(a, imm, 1'b0, 1'b0, 1'b1, tg);
            cpu_pkg::op_adc: do_arith(a, b, m_carry, 1'b0, 1'b1, tg);
            cpu_pkg::op_sub: do_arith(a, b, 1'b0, 1'b1, 1'b1, tg);
            cpu_pkg::op_suc: do_arith(a, b, m_carry, 1'b1, 1'b1, tg);
            cpu_pkg::op_cmp: do_arith(a, b, 1'b0, 1'b1, 1'b0, tg);
            cpu_pkg::op_cmi: do_arith(a, imm, 1'b0, 1'b1, 1'b0, tg);
            cpu_pkg::op_jmp: begin
                if (jump_taken(w.instr.jtype.cond)) begin
                    next_pc = imm[5:0];
                end
            end
            default: ;                            // nop
        endcase
        m_pc = next_pc;
    endtask

    initial begin : main
        logic [15:0] pick;
        logic        run_now;
        logic        exp_wr;
        logic        exp_rd;
        logic [15:0] exp_addr;
        logic [15:0] exp_wdata;
        int          executed;
        int          cycles;
        rst_n      = 1'b0;
        run        = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_wdata = '0;
        lfsr_state = 16'd73;
        m_pc       = '0;
        {m_ovf, m_lt, m_carry, m_eq} = 4'b0;
        for (int i = 0; i < 8; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            ext_mem[i] = 16'((i * 257) ^ 16'h5a3c);
            m_mem[i]   = ext_mem[i];
        end
        build_program();

        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        for (int a = 0; a <= 64; a++) begin      // last pass drops prog_we
            @(posedge clk);
            #1;
            prog_we = (a < 64);
            if (a < 64) begin
                prog_addr  = 6'(a);
                prog_wdata = prog[a];
            end
            #4;
            check("pc", 16'(pc), 16'd0);
            check("mem_req.write", 16'(mem_req.write), 16'd0);
            check("mem_req.read", 16'(mem_req.read), 16'd0);
        end

        executed = 0;
        cycles   = 0;
        while (executed < 2000) begin
            if (cycles >= 4000) begin
                $display("TB FAILED");
                $fatal(1, "timeout: core retired only %0d instructions", executed);
            end
            rand_bits(4, pick);
            run_now = (pick != 16'd0);           // occasional freeze
            @(posedge clk);
            #1 run = run_now;
            #4;
            check("pc", 16'(pc), 16'(m_pc));
            exp_wr = 1'b0;
            exp_rd = 1'b0;
            exp_addr = '0;
            exp_wdata = '0;
            if (run_now) begin
                model_step(exp_wr, exp_rd, exp_addr, exp_wdata);
                executed++;
            end
            check("mem_req.write", 16'(mem_req.write), 16'(exp_wr));
            check("mem_req.read", 16'(mem_req.read), 16'(exp_rd));
            if (exp_wr || exp_rd) begin
                check("mem_req.addr", mem_req.addr, exp_addr);
            end
            if (exp_wr) begin
                check("mem_req.wdata", mem_req.wdata, exp_wdata);
            end
            cycles++;
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- cpu_core.f
design/cpu_pkg.sv
design/instr_decoder.sv
design/fetch_unit.sv
design/reg_file.sv
design/alu.sv
design/cpu_core.sv
testbench/tb_cpu_core.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_cpu_core -f cpu_core.f -o tb_cpu_core
	./obj_dir/tb_cpu_core

clean:
	rm -rf obj_dir
